//--- design/credit_fifo_pkg.sv
/*
 * Shared sizes and payload type for the credit-based FIFO
 */
`default_nettype none

package credit_fifo_pkg;

  // --------------------
  // Storage sizing
  // --------------------

  // Number of RAM slots
  localparam int depth = 8;
  // Payload width in bits
  localparam int data_width = 8;
  // Read and write pointer width
  localparam int addr_width = 3;
  // Slot and item counters, range 0 to depth
  localparam int count_width = 4;

  // --------------------
  // Credit sizing
  // --------------------

  // Credits owned by the receiver out of reset
  localparam int max_credit = depth;
  // Credit counter and withhold amount
  localparam int credit_width = 4;

  // Default payload carried through the FIFO
  typedef logic [data_width-1:0] payload_t;

endpackage

`default_nettype wire

//--- design/credit_receiver.sv
/*
 * Credit receiver for the FIFO push side
 * Keeps the grantable credit count and issues one credit pulse per cycle
 */
`default_nettype none

module credit_receiver #(
  parameter type payload_t = credit_fifo_pkg::payload_t
) (
  input  wire logic                                    clk,
  input  wire logic                                    rst_n,
  input  wire logic                                    push_credit_stall,
  input  wire logic                                    push_valid,
  input  wire payload_t                                push_data,
  input  wire logic                                    pop_credit,
  input  wire logic [credit_fifo_pkg::credit_width-1:0] credit_withhold,
  output logic                                         push_credit,
  output logic                                         pop_valid,
  output payload_t                                     pop_data,
  output logic [credit_fifo_pkg::credit_width-1:0]      credit_count,
  output logic [credit_fifo_pkg::credit_width-1:0]      credit_available
);

  logic [credit_fifo_pkg::credit_width-1:0] credit_count_next;

  // --------------------
  // Credit grant
  // --------------------

  // Withheld credits stay with the receiver
  // Floor at zero when withhold exceeds the count
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

  // One credit per cycle while something is grantable
  // Stall acts in the same cycle
  assign push_credit = (credit_available != '0) && !push_credit_stall;

  // --------------------
  // Credit count
  // --------------------

  // Returned credit up, issued credit down
  // Both together leave the count alone
  always_comb begin
    credit_count_next = credit_count;
    if (pop_credit && !push_credit) begin
      // Never above the reset amount
      if (credit_count != credit_fifo_pkg::credit_width'(credit_fifo_pkg::max_credit)) begin
        credit_count_next = credit_count + credit_fifo_pkg::credit_width'(1);
      end
    end else if (push_credit && !pop_credit) begin
      credit_count_next = credit_count - credit_fifo_pkg::credit_width'(1);
    end
  end

  // All credits start on this side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_count <= credit_fifo_pkg::credit_width'(credit_fifo_pkg::max_credit);
    end else begin
      credit_count <= credit_count_next;
    end
  end

  // --------------------
  // Data path
  // --------------------

  // Sender only pushes on a held credit, so no qualification here
  assign pop_valid = push_valid;
  assign pop_data  = push_data;

endmodule

`default_nettype wire

//--- design/fifo_push_ctrl_credit.sv
/*
 * FIFO push controller with credit flow control
 * Turns credited pushes into RAM writes and tracks free slots
 */
`default_nettype none

module fifo_push_ctrl_credit (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  input  wire logic                                     push_credit_stall,
  input  wire logic                                     push_valid,
  input  wire credit_fifo_pkg::payload_t                push_data,
  input  wire logic [credit_fifo_pkg::credit_width-1:0] credit_withhold,
  input  wire logic                                     ram_pop,
  output logic                                          push_credit,
  output logic                                          full,
  output logic [credit_fifo_pkg::count_width-1:0]       slots,
  output logic [credit_fifo_pkg::credit_width-1:0]      credit_count,
  output logic [credit_fifo_pkg::credit_width-1:0]      credit_available,
  output logic                                          ram_wr_valid,
  output logic [credit_fifo_pkg::addr_width-1:0]        ram_wr_addr,
  output credit_fifo_pkg::payload_t                     ram_wr_data,
  output logic                                          ram_push
);

  logic                                     internal_valid;
  credit_fifo_pkg::payload_t                internal_data;
  logic [credit_fifo_pkg::count_width-1:0]  slots_next;

  // --------------------
  // Flow control
  // --------------------

  // Each slot freed by the pop side comes back as a credit
  credit_receiver i_credit_receiver (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .pop_credit        (ram_pop),
    .credit_withhold   (credit_withhold),
    .push_credit       (push_credit),
    .pop_valid         (internal_valid),
    .pop_data          (internal_data),
    .credit_count      (credit_count),
    .credit_available  (credit_available)
  );

  // --------------------
  // RAM write path
  // --------------------

  // No bypass, every accepted item lands in the RAM
  assign ram_push     = internal_valid;
  assign ram_wr_valid = ram_push;
  assign ram_wr_data  = internal_data;

  // Write pointer, wraps after the last slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_wr_addr <= '0;
    end else if (ram_wr_valid) begin
      if (ram_wr_addr == credit_fifo_pkg::addr_width'(credit_fifo_pkg::depth - 1)) begin
        ram_wr_addr <= '0;
      end else begin
        ram_wr_addr <= ram_wr_addr + credit_fifo_pkg::addr_width'(1);
      end
    end
  end

  // --------------------
  // Status flags
  // --------------------

  // Push takes a slot, pop gives one back
  always_comb begin
    case ({ram_push, ram_pop})
      2'b10:   slots_next = slots - credit_fifo_pkg::count_width'(1);
      2'b01:   slots_next = slots + credit_fifo_pkg::count_width'(1);
      default: slots_next = slots;
    endcase
  end

  // Empty FIFO out of reset, all slots free
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slots <= credit_fifo_pkg::count_width'(credit_fifo_pkg::depth);
      full  <= 1'b0;
    end else if (ram_push || ram_pop) begin
      slots <= slots_next;
      // Full once the last slot is taken
      full  <= (slots_next == '0);
    end
  end

endmodule

`default_nettype wire

//--- design/fifo_ram.sv
/*
 * Flop-based FIFO storage
 * One write port, one combinational read port
 */
`default_nettype none

module fifo_ram #(
  parameter type payload_t = credit_fifo_pkg::payload_t
) (
  input  wire logic                                  clk,
  input  wire logic                                  wr_valid,
  input  wire logic [credit_fifo_pkg::addr_width-1:0] wr_addr,
  input  wire payload_t                              wr_data,
  input  wire logic [credit_fifo_pkg::addr_width-1:0] rd_addr,
  output payload_t                                   rd_data
);

  // --------------------
  // Storage array
  // --------------------

  // Entries only read after being written
  payload_t mem [credit_fifo_pkg::depth];

  // Write on the clock edge
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read is combinational
  // New data visible the cycle after its write
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- design/fifo_pop_ctrl.sv
/*
 * FIFO pop controller
 * Read pointer, item count and empty flag, returns freed slots to the push side
 */
`default_nettype none

module fifo_pop_ctrl (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            ram_push,
  input  wire logic                            pop,
  output logic [credit_fifo_pkg::addr_width-1:0] ram_rd_addr,
  output logic                                 ram_pop,
  output logic                                 empty
);

  logic [credit_fifo_pkg::count_width-1:0] items;
  logic [credit_fifo_pkg::count_width-1:0] items_next;

  // --------------------
  // Pop qualification
  // --------------------

  // Pop on an empty FIFO is dropped here
  // Registered empty, so a same-cycle push cannot be popped yet
  assign ram_pop = pop && !empty;

  // --------------------
  // Read pointer
  // --------------------

  // Advances past the item just consumed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_rd_addr <= '0;
    end else if (ram_pop) begin
      if (ram_rd_addr == credit_fifo_pkg::addr_width'(credit_fifo_pkg::depth - 1)) begin
        ram_rd_addr <= '0;
      end else begin
        ram_rd_addr <= ram_rd_addr + credit_fifo_pkg::addr_width'(1);
      end
    end
  end

  // --------------------
  // Item count
  // --------------------

  // Mirror of the push side slot count
  always_comb begin
    case ({ram_push, ram_pop})
      2'b10:   items_next = items + credit_fifo_pkg::count_width'(1);
      2'b01:   items_next = items - credit_fifo_pkg::count_width'(1);
      default: items_next = items;
    endcase
  end

  // Nothing held out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else if (ram_push || ram_pop) begin
      items <= items_next;
      empty <= (items_next == '0);
    end
  end

endmodule

`default_nettype wire

//--- design/credit_fifo.sv
/*
 * Credit-based synchronous FIFO top level
 * Push controller, flop RAM and pop controller
 */
`default_nettype none

module credit_fifo (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  // Upstream sender
  input  wire logic                                     push_valid,
  input  wire credit_fifo_pkg::payload_t                push_data,
  input  wire logic                                     push_credit_stall,
  input  wire logic [credit_fifo_pkg::credit_width-1:0] credit_withhold,
  output logic                                          push_credit,
  output logic [credit_fifo_pkg::credit_width-1:0]      credit_count,
  output logic [credit_fifo_pkg::credit_width-1:0]      credit_available,
  // Status
  output logic                                          full,
  output logic [credit_fifo_pkg::count_width-1:0]       slots,
  // Pop side
  input  wire logic                                     pop,
  output credit_fifo_pkg::payload_t                     pop_data,
  output logic                                          empty
);

  // --------------------
  // Internal wiring
  // --------------------

  logic                                   ram_wr_valid;
  logic [credit_fifo_pkg::addr_width-1:0] ram_wr_addr;
  credit_fifo_pkg::payload_t              ram_wr_data;
  logic                                   ram_push;
  logic [credit_fifo_pkg::addr_width-1:0] ram_rd_addr;
  // Qualified pop, also the credit return
  logic                                   ram_pop;

  // Credit and write side
  fifo_push_ctrl_credit i_push_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .credit_withhold   (credit_withhold),
    .ram_pop           (ram_pop),
    .push_credit       (push_credit),
    .full              (full),
    .slots             (slots),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .ram_wr_valid      (ram_wr_valid),
    .ram_wr_addr       (ram_wr_addr),
    .ram_wr_data       (ram_wr_data),
    .ram_push          (ram_push)
  );

  // Storage, head item read straight out
  fifo_ram i_ram (
    .clk      (clk),
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .rd_addr  (ram_rd_addr),
    .rd_data  (pop_data)
  );

  // Read side
  fifo_pop_ctrl i_pop_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .ram_push    (ram_push),
    .pop         (pop),
    .ram_rd_addr (ram_rd_addr),
    .ram_pop     (ram_pop),
    .empty       (empty)
  );

endmodule

`default_nettype wire

//--- verification/credit_fifo_asserts.sv
/*
 * Bound checks on the FIFO push controller
 * Credit, slot and full flag consistency
 */
`default_nettype none

module credit_fifo_asserts (
  input wire logic                                    clk,
  input wire logic                                    rst_n,
  input wire logic                                    push_credit,
  input wire logic                                    full,
  input wire logic [credit_fifo_pkg::count_width-1:0] slots,
  input wire logic                                    ram_push,
  input wire logic                                    ram_pop
);

  // --------------------
  // Credit vs full
  // --------------------

  // No slot left, so nothing to grant
  full_blocks_credit: assert property (@(posedge clk) disable iff (!rst_n)
    full |-> !push_credit)
    else $error("push_credit was high while the FIFO was full");

  // Push into a full FIFO means a credit went missing
  push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    ram_push |-> !full)
    else $error("RAM push while the FIFO was full");

  // --------------------
  // Slot bookkeeping
  // --------------------

  slots_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    slots <= credit_fifo_pkg::count_width'(credit_fifo_pkg::depth))
    else $error("slot count above the FIFO depth");

  // A pop out of full frees one slot
  pop_clears_full: assert property (@(posedge clk) disable iff (!rst_n)
    full && ram_pop |=> !full)
    else $error("full stayed high after a pop");

endmodule

bind fifo_push_ctrl_credit credit_fifo_asserts i_credit_fifo_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .push_credit (push_credit),
  .full        (full),
  .slots       (slots),
  .ram_push    (ram_push),
  .ram_pop     (ram_pop)
);

`default_nettype wire

//--- verification/credit_fifo_tb.sv
/*
 * Testbench for the credit-based FIFO
 * Credit-holding sender model, scoreboard queue and phase table
 */
`default_nettype none

module credit_fifo_tb;

  logic                                     clk;
  logic                                     rst_n;
  logic                                     push_valid;
  credit_fifo_pkg::payload_t                push_data;
  logic                                     push_credit_stall;
  logic [credit_fifo_pkg::credit_width-1:0] credit_withhold;
  logic                                     push_credit;
  logic [credit_fifo_pkg::credit_width-1:0] credit_count;
  logic [credit_fifo_pkg::credit_width-1:0] credit_available;
  logic                                     full;
  logic [credit_fifo_pkg::count_width-1:0]  slots;
  logic                                     pop;
  credit_fifo_pkg::payload_t                pop_data;
  logic                                     empty;

  // One row per phase of traffic
  typedef struct packed {
    int cycles;
    int push_pct;
    int pop_pct;
    bit stall;
    int withhold;
    bit check_end;
    int exp_held;
    int exp_items;
  } phase_t;

  // cycles, push %, pop %, stall, withhold, check at end, held, items
  phase_t phases [12] = '{
    '{12, 0, 0, 1'b0, 0, 1'b1, 8, 0},
    '{12, 100, 0, 1'b0, 0, 1'b1, 0, 8},
    '{4, 0, 100, 1'b0, 0, 1'b1, 3, 4},
    '{10, 0, 100, 1'b0, 0, 1'b1, 8, 0},
    '{6, 0, 100, 1'b0, 0, 1'b1, 8, 0},
    '{200, 60, 50, 1'b0, 0, 1'b0, 0, 0},
    '{150, 80, 30, 1'b0, 3, 1'b0, 0, 0},
    '{60, 50, 50, 1'b1, 0, 1'b0, 0, 0},
    '{60, 70, 70, 1'b0, 12, 1'b0, 0, 0},
    '{100, 90, 20, 1'b0, 0, 1'b0, 0, 0},
    '{150, 20, 90, 1'b0, 1, 1'b0, 0, 0},
    '{30, 0, 100, 1'b0, 0, 1'b1, 8, 0}
  };

  // Sender and scoreboard state
  credit_fifo_pkg::payload_t sb_queue [$];
  credit_fifo_pkg::payload_t next_byte;
  int                        held;
  int                        cycle_index;
  int                        cycle_limit;
  int                        cycles_run;

  credit_fifo i_credit_fifo (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .push_credit_stall (push_credit_stall),
    .credit_withhold   (credit_withhold),
    .push_credit       (push_credit),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .full              (full),
    .slots             (slots),
    .pop               (pop),
    .pop_data          (pop_data),
    .empty             (empty)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Failure reporting
  // --------------------

  task automatic end_run_failed(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    end_run_failed($sformatf("CHECK FAILED at time %0t: %s", $time, what));
  endtask

  function automatic int total_cycles();
    int sum;
    sum = 0;
    foreach (phases[i]) begin
      sum += phases[i].cycles;
    end
    return sum;
  endfunction

  // Run length guard
  always @(posedge clk) begin
    cycles_run <= cycles_run + 1;
    if (cycles_run > cycle_limit) begin
      end_run_failed($sformatf("Timeout: the run went past its limit of %0d cycles",
                               cycle_limit));
    end
  end

  // --------------------
  // One clock cycle
  // --------------------

  // Starts on a rising edge, checks at the falling edge
  task automatic run_cycle(input phase_t ph);
    bit do_push;
    bit do_pop;
    int n;
    int model_count;
    int model_avail;
    bit exp_credit;
    do_push = (held > 0) && (int'($urandom % 100) < ph.push_pct);
    do_pop  = int'($urandom % 100) < ph.pop_pct;
    push_valid        <= do_push;
    push_data         <= next_byte;
    pop               <= do_pop;
    push_credit_stall <= ph.stall;
    credit_withhold   <= credit_fifo_pkg::credit_width'(ph.withhold);
    @(negedge clk);
    n = sb_queue.size();
    // Every credit is either in the receiver, with the sender or a held item
    model_count = credit_fifo_pkg::max_credit - held - n;
    model_avail = (model_count > ph.withhold) ? model_count - ph.withhold : 0;
    exp_credit  = (model_avail != 0) && !ph.stall;
    if (cycle_index == 0) begin
      assert (int'(slots) == credit_fifo_pkg::depth && empty && !full)
        else report_mismatch("status after reset is not an empty FIFO");
      assert (int'(credit_count) == credit_fifo_pkg::max_credit)
        else report_mismatch("credit count after reset is not the full amount");
    end
    assert (int'(credit_count) == model_count)
      else report_mismatch($sformatf("credit_count %0d, expected %0d",
                                     credit_count, model_count));
    assert (int'(credit_available) == model_avail)
      else report_mismatch($sformatf("credit_available %0d, expected %0d",
                                     credit_available, model_avail));
    assert (push_credit == exp_credit)
      else report_mismatch($sformatf("push_credit %0b, expected %0b",
                                     push_credit, exp_credit));
    assert (!(ph.stall && push_credit))
      else report_mismatch("push_credit high during stall");
    assert (!(push_credit && credit_available == '0))
      else report_mismatch("push_credit high with no credit available");
    assert (int'(slots) == credit_fifo_pkg::depth - n)
      else report_mismatch($sformatf("slots %0d, expected %0d",
                                     slots, credit_fifo_pkg::depth - n));
    assert (full == (n == credit_fifo_pkg::depth) && full == (slots == '0))
      else report_mismatch($sformatf("full %0b with %0d items held", full, n));
    assert (empty == (n == 0))
      else report_mismatch($sformatf("empty %0b with %0d items held", empty, n));
    // Head of the FIFO always visible
    if (n > 0) begin
      assert (pop_data == sb_queue[0])
        else report_mismatch($sformatf("pop_data %02h, expected %02h",
                                       pop_data, sb_queue[0]));
    end
    // Pop on empty is ignored
    if (do_pop && n > 0) begin
      void'(sb_queue.pop_front());
    end
    if (do_push) begin
      sb_queue.push_back(next_byte);
      next_byte = next_byte + credit_fifo_pkg::payload_t'(1);
    end
    held = held + int'(push_credit) - int'(do_push);
    cycle_index++;
    @(posedge clk);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    rst_n             = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    push_credit_stall = 1'b0;
    credit_withhold   = '0;
    pop               = 1'b0;
    next_byte         = '0;
    held              = 0;
    cycle_index       = 0;
    cycles_run        = 0;
    void'($urandom(28));
    cycle_limit = total_cycles() + 100;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    foreach (phases[i]) begin
      $display("Phase %0d: %0d cycles", i, phases[i].cycles);
      repeat (phases[i].cycles) run_cycle(phases[i]);
      if (phases[i].check_end) begin
        assert (held == phases[i].exp_held)
          else report_mismatch($sformatf("sender holds %0d credits, expected %0d",
                                         held, phases[i].exp_held));
        assert (sb_queue.size() == phases[i].exp_items)
          else report_mismatch($sformatf("%0d items held, expected %0d",
                                         sb_queue.size(), phases[i].exp_items));
      end
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/credit_fifo_pkg.sv
design/credit_receiver.sv
design/fifo_push_ctrl_credit.sv
design/fifo_ram.sv
design/fifo_pop_ctrl.sv
design/credit_fifo.sv
verification/credit_fifo_asserts.sv
verification/credit_fifo_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the credit FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module credit_fifo_tb \
  -f sources.f -o credit_fifo_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/credit_fifo_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF "All tests passed!"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
